//--- Bender.yml
package:
  name: tmr_group

sources:
  - hw/tmr_pkg.sv
  - hw/tmr_regs.sv
  - hw/tmr_voter.sv
  - hw/tmr_ctrl.sv
  - hw/tmr_group_top.sv
  - target: test
    files:
      - bench/tmr_checker.sv
      - bench/tb_tmr_group.sv

//--- bench/tb_tmr_group.sv
//********************************************************************
// Testbench for the TMR group controller
// Clock, reset, stimulus table, credit return and timeout
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_tmr_group import tmr_pkg::*; ();

  localparam int unsigned DataWidth = 32;
  localparam int unsigned Credits   = 4;
  localparam logic [DataWidth-1:0] Corrupt = 32'h0000_00a5;
  localparam int OpNone   = 0;
  localparam int OpWr     = 1;
  localparam int OpRd     = 2;
  localparam int MaxSteps = 64;

  logic                 clk, rst_n;
  logic                 reg_valid, reg_write;
  logic [RegAddrW-1:0]  reg_addr;
  logic [RegDataW-1:0]  reg_wdata, reg_rdata;
  logic                 core_valid, stall, out_valid, credit;
  logic [DataWidth-1:0] core0_data, core1_data, core2_data, out_data;
  logic                 fetch_en, cores_synch, setback, independent;
  tmr_mode_e            mode;
  // Expected values passed to the checker
  tmr_mode_e            exp_mode;
  logic                 exp_setback, rd_check, active;
  logic [RegDataW-1:0]  exp_rdata;
  int                   checks, errors, last_checks, last_errors;
  int                   seed, cycles, limit, n_steps, cur_test;
  logic [DataWidth-1:0] base;

  // Stimulus table, one entry per step
  int                   op_t     [MaxSteps];
  logic [RegAddrW-1:0]  addr_t   [MaxSteps];
  logic [RegDataW-1:0]  wdata_t  [MaxSteps];
  logic                 valid_t  [MaxSteps];
  int                   bad_t    [MaxSteps];
  logic                 fetch_t  [MaxSteps];
  logic                 synch_t  [MaxSteps];
  logic                 credit_t [MaxSteps];
  logic [RegDataW-1:0]  rdata_t  [MaxSteps];
  tmr_mode_e            mode_t   [MaxSteps];
  logic                 sb_t     [MaxSteps];
  int                   test_t   [MaxSteps];

  tmr_group_top #(
    .DataWidth (DataWidth),
    .CntWidth  (8),
    .Credits   (Credits),
    .TMRFixed  (1'b0)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .core_valid_i  (core_valid),
    .core0_data_i  (core0_data),
    .core1_data_i  (core1_data),
    .core2_data_i  (core2_data),
    .stall_o       (stall),
    .out_valid_o   (out_valid),
    .out_data_o    (out_data),
    .credit_i      (credit),
    .fetch_en_i    (fetch_en),
    .cores_synch_i (cores_synch),
    .setback_o     (setback),
    .mode_o        (mode),
    .independent_o (independent)
  );

  tmr_checker #(
    .DataWidth (DataWidth),
    .Credits   (Credits)
  ) u_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .active_i      (active),
    .core_valid_i  (core_valid),
    .core0_data_i  (core0_data),
    .core1_data_i  (core1_data),
    .core2_data_i  (core2_data),
    .credit_i      (credit),
    .stall_i       (stall),
    .out_valid_i   (out_valid),
    .out_data_i    (out_data),
    .reg_rdata_i   (reg_rdata),
    .mode_i        (mode),
    .independent_i (independent),
    .setback_i     (setback),
    .exp_mode_i    (exp_mode),
    .exp_setback_i (exp_setback),
    .rd_check_i    (rd_check),
    .exp_rdata_i   (exp_rdata),
    .checks_o      (checks),
    .errors_o      (errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic string test_name(input int id);
    case (id)
      1:       return "register access";
      2:       return "equal lanes";
      3:       return "single lane fault";
      4:       return "unload and reload";
      5:       return "output credits";
      6:       return "independent mode";
      default: return "unknown";
    endcase
  endfunction

  task automatic add_step(input int op, input logic [RegAddrW-1:0] addr,
                          input logic [RegDataW-1:0] wdata, input logic valid,
                          input int bad, input logic fetch, input logic synch,
                          input logic cred, input logic [RegDataW-1:0] rdata,
                          input tmr_mode_e md, input logic sb);
    op_t[n_steps]     = op;
    addr_t[n_steps]   = addr;
    wdata_t[n_steps]  = wdata;
    valid_t[n_steps]  = valid;
    bad_t[n_steps]    = bad;
    fetch_t[n_steps]  = fetch;
    synch_t[n_steps]  = synch;
    credit_t[n_steps] = cred;
    rdata_t[n_steps]  = rdata;
    mode_t[n_steps]   = md;
    sb_t[n_steps]     = sb;
    test_t[n_steps]   = cur_test;
    n_steps++;
  endtask

  // Columns: op, addr, wdata, valid, bad lane (3 none, 4 all differ), fetch_en,
  // cores_synch, credit, read data seen next cycle, mode and setback this cycle
  task automatic build_table();
    cur_test = 1;
    add_step(OpWr,   ADDR_CTRL,      32'h17, 0, 3, 0, 0, 0, 32'h0, NON_TMR, 0);
    add_step(OpRd,   ADDR_CTRL,      32'h0,  0, 3, 0, 0, 0, 32'h7, NON_TMR, 0);
    add_step(OpWr,   ADDR_SP_STORE,  32'hcafe_0001, 0, 3, 0, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   ADDR_SP_STORE,  32'h0, 0, 3, 0, 0, 0, 32'hcafe_0001, TMR_RUN, 0);
    add_step(OpWr,   ADDR_SP_STORE,  32'h0,  0, 3, 0, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   4'ha,           32'h0,  0, 3, 0, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   ADDR_STATUS,    32'h0,  0, 3, 0, 0, 0, 32'h1, TMR_RUN, 0);
    cur_test = 2;
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 0, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 0, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    cur_test = 3;
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 1, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   ADDR_MISMATCH1, 32'h0,  0, 3, 1, 0, 0, 32'h1, TMR_UNLOAD, 0);
    add_step(OpWr,   ADDR_MISMATCH1, 32'hff, 0, 3, 1, 0, 0, 32'h0, TMR_UNLOAD, 0);
    add_step(OpRd,   ADDR_MISMATCH1, 32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_UNLOAD, 0);
    cur_test = 4;
    add_step(OpWr,   ADDR_SP_STORE,  32'h40, 0, 3, 1, 0, 0, 32'h0, TMR_UNLOAD, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_UNLOAD, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 4, 1, 0, 0, 32'h0, TMR_RELOAD, 1);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 1, 32'h0, TMR_RELOAD, 0);
    add_step(OpWr,   ADDR_SP_STORE,  32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RELOAD, 1);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RELOAD, 0);
    add_step(OpRd,   ADDR_MISMATCH2, 32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpWr,   ADDR_CTRL,      32'h0f, 0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 0, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   ADDR_MISMATCH0, 32'h0,  0, 3, 1, 0, 0, 32'h1, TMR_RUN, 0);
    add_step(OpWr,   ADDR_CTRL,      32'h07, 0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    cur_test = 5;
    // Six beats offered without credits, only four fit
    for (int k = 0; k < 6; k++) begin
      add_step(OpNone, ADDR_CTRL,    32'h0,  1, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    end
    // Two credits back, two more beats
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    for (int k = 0; k < 4; k++) begin
      add_step(OpNone, ADDR_CTRL,    32'h0,  0, 3, 1, 0, 1, 32'h0, TMR_RUN, 0);
    end
    cur_test = 6;
    add_step(OpWr,   ADDR_CTRL,      32'h06, 0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, NON_TMR, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 0, 1, 0, 0, 32'h0, NON_TMR, 0);
    add_step(OpWr,   ADDR_CTRL,      32'h07, 0, 3, 1, 0, 1, 32'h0, NON_TMR, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, NON_TMR, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 1, 0, 32'h0, NON_TMR, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  1, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
    add_step(OpRd,   ADDR_MISMATCH0, 32'h0,  0, 3, 1, 0, 1, 32'h1, TMR_RUN, 0);
    add_step(OpRd,   ADDR_STATUS,    32'h0,  0, 3, 1, 0, 0, 32'h1, TMR_RUN, 0);
    add_step(OpNone, ADDR_CTRL,      32'h0,  0, 3, 1, 0, 0, 32'h0, TMR_RUN, 0);
  endtask

  task automatic report_test(input int id);
    $display("Test %0d %s: %0d checks, %0d errors", id, test_name(id),
             checks - last_checks, errors - last_errors);
    last_checks = checks;
    last_errors = errors;
  endtask

  // Cycle limit from the table length
  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    reg_valid   = 1'b0;
    reg_write   = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    core_valid  = 1'b0;
    core0_data  = '0;
    core1_data  = '0;
    core2_data  = '0;
    credit      = 1'b0;
    fetch_en    = 1'b0;
    cores_synch = 1'b0;
    exp_mode    = NON_TMR;
    exp_setback = 1'b0;
    rd_check    = 1'b0;
    exp_rdata   = '0;
    active      = 1'b0;
    last_checks = 0;
    last_errors = 0;
    n_steps     = 0;
    limit       = 0;
    seed        = 80;
    build_table();
    limit = n_steps * 4 + 20;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < n_steps; i++) begin
      @(posedge clk);
      base = $random(seed);
      reg_valid   <= op_t[i] != OpNone;
      reg_write   <= op_t[i] == OpWr;
      reg_addr    <= addr_t[i];
      reg_wdata   <= wdata_t[i];
      core_valid  <= valid_t[i];
      // Single lane corruption, or three distinct values for code 4
      // with lane 0 away from the bitwise majority
      core0_data  <= base ^ ((bad_t[i] == 0 || bad_t[i] == 4) ? Corrupt : '0);
      core1_data  <= base ^ ((bad_t[i] == 1) ? Corrupt :
                             (bad_t[i] == 4) ? (Corrupt << 8) : '0);
      core2_data  <= base ^ ((bad_t[i] == 2) ? Corrupt : '0);
      fetch_en    <= fetch_t[i];
      cores_synch <= synch_t[i];
      credit      <= credit_t[i];
      exp_mode    <= mode_t[i];
      exp_setback <= sb_t[i];
      rd_check    <= op_t[i] == OpRd;
      exp_rdata   <= rdata_t[i];
      active      <= 1'b1;
      // Previous test is done once its last read has been compared
      if (i > 0 && test_t[i] != test_t[i-1]) begin
        @(negedge clk);
        #1;
        report_test(test_t[i-1]);
      end
    end
    @(negedge clk);
    #1;
    report_test(test_t[n_steps-1]);

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tmr_checker.sv
//********************************************************************
// Checker for the TMR group testbench
// Models vote, credits and register reads, compares DUT outputs
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tmr_checker import tmr_pkg::*; #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned Credits   = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 active_i,
  // DUT ports under watch
  input  wire logic                 core_valid_i,
  input  wire logic [DataWidth-1:0] core0_data_i,
  input  wire logic [DataWidth-1:0] core1_data_i,
  input  wire logic [DataWidth-1:0] core2_data_i,
  input  wire logic                 credit_i,
  input  wire logic                 stall_i,
  input  wire logic                 out_valid_i,
  input  wire logic [DataWidth-1:0] out_data_i,
  input  wire logic [RegDataW-1:0]  reg_rdata_i,
  input  wire tmr_mode_e            mode_i,
  input  wire logic                 independent_i,
  input  wire logic                 setback_i,
  // Expected values of the current step
  input  wire tmr_mode_e            exp_mode_i,
  input  wire logic                 exp_setback_i,
  input  wire logic                 rd_check_i,
  input  wire logic [RegDataW-1:0]  exp_rdata_i,
  // Running totals
  output int                        checks_o,
  output int                        errors_o
);

  int                   credits;
  logic                 beat_due;
  logic [DataWidth-1:0] beat_data;
  logic                 rd_due;
  logic [RegDataW-1:0]  rd_data;

  // Value shared by at least two lanes, lane 0 when none agree
  function automatic logic [DataWidth-1:0] majority_value(input logic [DataWidth-1:0] a,
                                                          input logic [DataWidth-1:0] b,
                                                          input logic [DataWidth-1:0] c);
    if (a == b || a == c) begin
      return a;
    end
    if (b == c) begin
      return b;
    end
    return a;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] obs);
    checks_o++;
    if (exp !== obs) begin
      errors_o++;
      $display("Fail at %0t ns: %s expected %0h observed %0h", $time, name, exp, obs);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits  = Credits;
      beat_due = 1'b0;
      rd_due   = 1'b0;
      checks_o = 0;
      errors_o = 0;
    end else begin
      if (active_i) begin
        // Beat accepted one cycle earlier
        compare_value("out_valid_o", beat_due, out_valid_i);
        if (beat_due) begin
          compare_value("out_data_o", beat_data, out_data_i);
        end
        // Read requested one cycle earlier
        if (rd_due) begin
          compare_value("reg_rdata_o", rd_data, reg_rdata_i);
        end
        compare_value("stall_o", credits == 0, stall_i);
        compare_value("mode_o", exp_mode_i, mode_i);
        compare_value("independent_o", exp_mode_i == NON_TMR, independent_i);
        compare_value("setback_o", exp_setback_i, setback_i);
      end
      // Accept and credit model for the coming edge
      beat_due = core_valid_i && (credits > 0);
      if (beat_due) begin
        // Lane 0 passes unchecked outside lockstep
        beat_data = (exp_mode_i == NON_TMR) ? core0_data_i :
                    majority_value(core0_data_i, core1_data_i, core2_data_i);
      end
      credits = credits - int'(beat_due) + int'(credit_i);
      rd_due  = active_i && rd_check_i;
      rd_data = exp_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/tmr_ctrl.sv
//********************************************************************
// TMR mode state machine: run, unload, reload, independent
// Counter increments and setback pulse generation
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tmr_ctrl import tmr_pkg::*; #(
  parameter bit TMRFixed = 1'b0
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Configuration from the register block
  input  wire logic       enable_i,
  input  wire logic       setback_en_i,
  input  wire logic       reload_setback_i,
  input  wire logic       delay_resynch_i,
  input  wire logic       force_resynch_i,
  input  wire logic       sp_stored_i,
  input  wire logic       sp_clear_wr_i,
  // Voter status
  input  wire logic       mismatch_i,
  input  wire logic [2:0] lane_err_i,
  input  wire logic       fail_i,
  // Core group status
  input  wire logic       fetch_en_i,
  input  wire logic       cores_synch_i,
  // Control outputs
  output tmr_mode_e       mode_o,
  output logic            independent_o,
  output logic      [2:0] incr_o,
  output logic            setback_o
);

  localparam tmr_mode_e ResetMode = TMRFixed ? TMR_RUN : NON_TMR;

  tmr_mode_e mode_d, mode_q;
  logic      setback_d, setback_q;

  assign mode_o        = mode_q;
  assign setback_o     = setback_q;
  assign independent_o = mode_q == NON_TMR;

  always_comb begin
    mode_d    = mode_q;
    setback_d = 1'b0;
    incr_o    = 3'b000;

    case (mode_q)
      TMR_RUN: begin
        // Count the lanes that disagreed
        if (mismatch_i) begin
          incr_o = lane_err_i;
        end
        // Forced resynch behaves like a mismatch without counting
        if ((mismatch_i || force_resynch_i) && !delay_resynch_i) begin
          mode_d = TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        // Cores have saved their state
        if (sp_stored_i) begin
          mode_d    = TMR_RELOAD;
          setback_d = setback_en_i;
        end
      end
      TMR_RELOAD: begin
        if (!sp_stored_i) begin
          mode_d = TMR_RUN;
        end else if ((mismatch_i || fail_i) && setback_en_i && reload_setback_i &&
                     !sp_clear_wr_i) begin
          // Error during restore, restart it
          setback_d = 1'b1;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    // Software mode control, only when redundancy is optional
    if (!TMRFixed) begin
      // Before fetch starts the mode just follows enable
      if (!fetch_en_i) begin
        mode_d = enable_i ? TMR_RUN : NON_TMR;
      end
      // Leave lockstep at any time
      if (mode_q == TMR_RUN && !enable_i) begin
        mode_d = NON_TMR;
      end
      // Enter lockstep once the cores report they are synchronized
      if (mode_q == NON_TMR && cores_synch_i && enable_i) begin
        mode_d = TMR_RUN;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= ResetMode;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/tmr_group_top.sv
//********************************************************************
// TMR group top level
// Connects register block, mode controller and voter
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tmr_group_top import tmr_pkg::*; #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned CntWidth  = 8,
  parameter int unsigned Credits   = 4,
  parameter bit          TMRFixed  = 1'b0
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Register bus
  input  wire logic                 reg_valid_i,
  input  wire logic                 reg_write_i,
  input  wire logic [RegAddrW-1:0]  reg_addr_i,
  input  wire logic [RegDataW-1:0]  reg_wdata_i,
  output logic      [RegDataW-1:0]  reg_rdata_o,
  // Core lanes
  input  wire logic                 core_valid_i,
  input  wire logic [DataWidth-1:0] core0_data_i,
  input  wire logic [DataWidth-1:0] core1_data_i,
  input  wire logic [DataWidth-1:0] core2_data_i,
  output logic                      stall_o,
  // Voted output
  output logic                      out_valid_o,
  output logic      [DataWidth-1:0] out_data_o,
  input  wire logic                 credit_i,
  // Group control
  input  wire logic                 fetch_en_i,
  input  wire logic                 cores_synch_i,
  output logic                      setback_o,
  output tmr_mode_e                 mode_o,
  output logic                      independent_o
);

  logic       enable, setback_en, reload_setback, delay_resynch, force_resynch;
  logic       sp_stored, sp_clear_wr;
  logic       mismatch, fail;
  logic [2:0] lane_err, incr;

  tmr_regs #(
    .CntWidth (CntWidth)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .incr_i           (incr),
    .mode_i           (mode_o),
    .enable_o         (enable),
    .setback_en_o     (setback_en),
    .reload_setback_o (reload_setback),
    .delay_resynch_o  (delay_resynch),
    .force_resynch_o  (force_resynch),
    .sp_stored_o      (sp_stored),
    .sp_clear_wr_o    (sp_clear_wr)
  );

  tmr_voter #(
    .DataWidth (DataWidth),
    .Credits   (Credits)
  ) u_voter (
    .clk_i,
    .rst_ni,
    .core_valid_i,
    .core0_data_i,
    .core1_data_i,
    .core2_data_i,
    .stall_o,
    .out_valid_o,
    .out_data_o,
    .credit_i,
    .independent_i (independent_o),
    .mismatch_o    (mismatch),
    .lane_err_o    (lane_err),
    .fail_o        (fail)
  );

  tmr_ctrl #(
    .TMRFixed (TMRFixed)
  ) u_ctrl (
    .clk_i,
    .rst_ni,
    .enable_i         (enable),
    .setback_en_i     (setback_en),
    .reload_setback_i (reload_setback),
    .delay_resynch_i  (delay_resynch),
    .force_resynch_i  (force_resynch),
    .sp_stored_i      (sp_stored),
    .sp_clear_wr_i    (sp_clear_wr),
    .mismatch_i       (mismatch),
    .lane_err_i       (lane_err),
    .fail_i           (fail),
    .fetch_en_i,
    .cores_synch_i,
    .mode_o,
    .independent_o,
    .incr_o           (incr),
    .setback_o
  );

endmodule

`default_nettype wire

//--- hw/tmr_pkg.sv
//********************************************************************
// Shared definitions for the TMR group controller
// Redundancy mode encoding, register map and CTRL bit positions
//********************************************************************

`default_nettype none

package tmr_pkg;

  // Redundancy mode of the core group
  typedef enum logic [1:0] {
    NON_TMR    = 2'd0,
    TMR_RUN    = 2'd1,
    TMR_UNLOAD = 2'd2,
    TMR_RELOAD = 2'd3
  } tmr_mode_e;

  // Register bus widths
  parameter int unsigned RegAddrW = 4;
  parameter int unsigned RegDataW = 32;

  // Register map
  parameter logic [RegAddrW-1:0] ADDR_CTRL      = 4'h0;
  parameter logic [RegAddrW-1:0] ADDR_SP_STORE  = 4'h1;
  parameter logic [RegAddrW-1:0] ADDR_MISMATCH0 = 4'h2;
  parameter logic [RegAddrW-1:0] ADDR_MISMATCH1 = 4'h3;
  parameter logic [RegAddrW-1:0] ADDR_MISMATCH2 = 4'h4;
  parameter logic [RegAddrW-1:0] ADDR_STATUS    = 4'h5;

  // CTRL register fields
  parameter int unsigned CTRL_ENABLE_BIT         = 0;
  parameter int unsigned CTRL_SETBACK_BIT        = 1;
  parameter int unsigned CTRL_RELOAD_SETBACK_BIT = 2;
  parameter int unsigned CTRL_DELAY_RESYNCH_BIT  = 3;
  // Self-clearing, always reads as zero
  parameter int unsigned CTRL_FORCE_RESYNCH_BIT  = 4;

endpackage

`default_nettype wire

//--- hw/tmr_regs.sv
//********************************************************************
// TMR register block: CTRL bits, stack-pointer store word,
// saturating per-core mismatch counters and status readback
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tmr_regs import tmr_pkg::*; #(
  parameter int unsigned CntWidth = 8
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Register bus
  input  wire logic                reg_valid_i,
  input  wire logic                reg_write_i,
  input  wire logic [RegAddrW-1:0] reg_addr_i,
  input  wire logic [RegDataW-1:0] reg_wdata_i,
  output logic      [RegDataW-1:0] reg_rdata_o,
  // Hardware side
  input  wire logic [2:0]          incr_i,
  input  wire tmr_mode_e           mode_i,
  output logic                     enable_o,
  output logic                     setback_en_o,
  output logic                     reload_setback_o,
  output logic                     delay_resynch_o,
  output logic                     force_resynch_o,
  output logic                     sp_stored_o,
  output logic                     sp_clear_wr_o
);

  logic                wr_en, rd_en;
  logic                ctrl_wr, sp_wr;
  logic [2:0]          cnt_wr;
  logic [RegDataW-1:0] sp_q;
  logic [CntWidth-1:0] cnt_q [3];
  logic [RegDataW-1:0] rdata_d;

  // Bus is always ready, one access per valid cycle
  assign wr_en = reg_valid_i & reg_write_i;
  assign rd_en = reg_valid_i & ~reg_write_i;

  assign ctrl_wr   = wr_en && (reg_addr_i == ADDR_CTRL);
  assign sp_wr     = wr_en && (reg_addr_i == ADDR_SP_STORE);
  assign cnt_wr[0] = wr_en && (reg_addr_i == ADDR_MISMATCH0);
  assign cnt_wr[1] = wr_en && (reg_addr_i == ADDR_MISMATCH1);
  assign cnt_wr[2] = wr_en && (reg_addr_i == ADDR_MISMATCH2);

  // Saved state is present while the store word is nonzero
  assign sp_stored_o   = |sp_q;
  // Software signals restore done by writing zero
  assign sp_clear_wr_o = sp_wr && (reg_wdata_i == '0);

  // CTRL levels and the force pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_o         <= 1'b0;
      setback_en_o     <= 1'b0;
      reload_setback_o <= 1'b0;
      delay_resynch_o  <= 1'b0;
      force_resynch_o  <= 1'b0;
      sp_q             <= '0;
    end else begin
      // Force lasts a single cycle after the write
      force_resynch_o <= ctrl_wr & reg_wdata_i[CTRL_FORCE_RESYNCH_BIT];
      if (ctrl_wr) begin
        enable_o         <= reg_wdata_i[CTRL_ENABLE_BIT];
        setback_en_o     <= reg_wdata_i[CTRL_SETBACK_BIT];
        reload_setback_o <= reg_wdata_i[CTRL_RELOAD_SETBACK_BIT];
        delay_resynch_o  <= reg_wdata_i[CTRL_DELAY_RESYNCH_BIT];
      end
      if (sp_wr) begin
        sp_q <= reg_wdata_i;
      end
    end
  end

  // Mismatch counters, a bus write of any value wins over an increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < 3; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < 3; k++) begin
        if (cnt_wr[k]) begin
          cnt_q[k] <= '0;
        end else if (incr_i[k] && (cnt_q[k] != '1)) begin
          // Saturate at all ones
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      ADDR_CTRL: begin
        rdata_d[CTRL_ENABLE_BIT]         = enable_o;
        rdata_d[CTRL_SETBACK_BIT]        = setback_en_o;
        rdata_d[CTRL_RELOAD_SETBACK_BIT] = reload_setback_o;
        rdata_d[CTRL_DELAY_RESYNCH_BIT]  = delay_resynch_o;
      end
      ADDR_SP_STORE:  rdata_d = sp_q;
      ADDR_MISMATCH0: rdata_d = RegDataW'(cnt_q[0]);
      ADDR_MISMATCH1: rdata_d = RegDataW'(cnt_q[1]);
      ADDR_MISMATCH2: rdata_d = RegDataW'(cnt_q[2]);
      ADDR_STATUS:    rdata_d[1:0] = mode_i;
      default:        rdata_d = '0;
    endcase
  end

  // Read data is valid one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rdata_o <= '0;
    end else if (rd_en) begin
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/tmr_voter.sv
//********************************************************************
// Three-lane majority voter with per-lane mismatch flags,
// output credit counter and upstream stall
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned Credits   = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Core lanes
  input  wire logic                 core_valid_i,
  input  wire logic [DataWidth-1:0] core0_data_i,
  input  wire logic [DataWidth-1:0] core1_data_i,
  input  wire logic [DataWidth-1:0] core2_data_i,
  output logic                      stall_o,
  // Voted output port
  output logic                      out_valid_o,
  output logic      [DataWidth-1:0] out_data_o,
  input  wire logic                 credit_i,
  // Mode and error reporting
  input  wire logic                 independent_i,
  output logic                      mismatch_o,
  output logic      [2:0]           lane_err_o,
  output logic                      fail_o
);

  localparam int unsigned CredW = $clog2(Credits + 1);

  logic                 accept;
  logic [DataWidth-1:0] majority;
  logic [2:0]           lane_diff;
  logic                 all_differ;
  logic [CredW-1:0]     credit_q;

  // Bitwise two-of-three vote
  assign majority = (core0_data_i & core1_data_i) |
                    (core0_data_i & core2_data_i) |
                    (core1_data_i & core2_data_i);

  assign lane_diff[0] = core0_data_i != majority;
  assign lane_diff[1] = core1_data_i != majority;
  assign lane_diff[2] = core2_data_i != majority;

  // No two lanes agree, vote is meaningless
  assign all_differ = (core0_data_i != core1_data_i) &&
                      (core0_data_i != core2_data_i) &&
                      (core1_data_i != core2_data_i);

  // Cores hold their lanes while no credit is left
  assign stall_o = credit_q == '0;
  assign accept  = core_valid_i & ~stall_o;

  // Credit count, accept and return may coincide
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CredW'(Credits);
    end else begin
      case ({accept, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Output stage, one cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
      mismatch_o  <= 1'b0;
      lane_err_o  <= '0;
      fail_o      <= 1'b0;
    end else begin
      out_valid_o <= accept;
      // Flags only in TMR mode and only with a beat
      mismatch_o  <= accept & ~independent_i & (|lane_diff);
      lane_err_o  <= (accept & ~independent_i) ? lane_diff : 3'b000;
      fail_o      <= accept & ~independent_i & all_differ;
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      // Lane 0 in independent mode or on failure
      out_data_o <= (independent_i || all_differ) ? core0_data_i : majority;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
hw/tmr_pkg.sv
hw/tmr_regs.sv
hw/tmr_voter.sv
hw/tmr_ctrl.sv
hw/tmr_group_top.sv
bench/tmr_checker.sv
bench/tb_tmr_group.sv
